// ==== onboard_copy.f ====
source/copy_desc_pkg.sv
source/copy_ctrl_pkg.sv
source/copy_cmd_decode.sv
source/chunk_gen.sv
source/chunk_fifo.sv
source/cmd_issue.sv
source/onboard_copy_top.sv
verification/onboard_copy_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the copy engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module onboard_copy_tb -f onboard_copy.f -o onboard_copy_sim \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/onboard_copy_sim)"
printf '%s\n' "$sim_out"

grep -qx "Everything OK" <<< "$sim_out" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/onboard_copy_tb.sv ====
// on-board copy engine testbench
// table of copy commands, downstream read/write model and result checks
`default_nettype none

module onboard_copy_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          n_rows          = 4;
    localparam int          page_bytes      = 4096;
    localparam int          beat_size       = 64;
    localparam int          max_outstanding = 97;   // credit limit plus one largest chunk
    localparam logic [7:0]  fn_value        = 8'h2a;

    // one table row: command, hold flag and expected minimum command count
    typedef struct packed {
        copy_desc_pkg::copy_cfg_t cfg;
        logic                     hold;       // withhold wr_data_ren for a while
        logic [15:0]              min_cmds;   // 4 KiB pages touched
    } row_t;

    logic                       afu_pcie_core_clk;
    logic                       afu_pcie_core_rst;
    logic                       copy_cmd_valid;
    copy_desc_pkg::copy_cfg_t   copy_cfg;
    copy_ctrl_pkg::work_mode_e  work_mode;
    logic                       work_en;
    logic [7:0]                 function_num;
    logic                       rd_cmd_valid;
    copy_desc_pkg::xfer_cmd_t   rd_cmd;
    logic                       wr_cmd_valid;
    copy_desc_pkg::xfer_cmd_t   wr_cmd;
    logic                       rd_data_valid;
    copy_desc_pkg::data_beat_t  rd_beat;
    logic                       wr_data_ren;
    logic                       wr_data_valid;
    copy_desc_pkg::data_beat_t  wr_beat;
    logic [15:0]                gen_count;
    logic                       copy_done;
    logic [31:0]                time_cost;

    row_t                       rows [n_rows];
    copy_desc_pkg::copy_cfg_t   cur_cfg;
    copy_desc_pkg::data_beat_t  beat_q [$];         // read data owed to the DUT
    logic [63:0]                run_off;            // offset of the next expected command
    logic [31:0]                lfsr_state = 32'h9c46;
    logic                       row_active = 1'b0;
    logic                       hold_ren = 1'b0;
    logic                       timed_out = 1'b0;
    int                         cmd_count = 0;
    int                         issued_beats = 0;
    int                         consumed_beats = 0;
    int                         unconsumed = 0;     // forwarded, not yet taken
    int                         fwd_count = 0;
    int                         check_count = 0;
    int                         error_count = 0;
    int                         timeout_count = 0;

    onboard_copy_top #(
        .credit_limit (32)
    ) dut (
        .afu_pcie_core_clk (afu_pcie_core_clk),
        .afu_pcie_core_rst (afu_pcie_core_rst),
        .copy_cmd_valid    (copy_cmd_valid),
        .copy_cfg          (copy_cfg),
        .work_mode         (work_mode),
        .work_en           (work_en),
        .function_num      (function_num),
        .rd_cmd_valid      (rd_cmd_valid),
        .rd_cmd            (rd_cmd),
        .wr_cmd_valid      (wr_cmd_valid),
        .wr_cmd            (wr_cmd),
        .rd_data_valid     (rd_data_valid),
        .rd_beat           (rd_beat),
        .wr_data_ren       (wr_data_ren),
        .wr_data_valid     (wr_data_valid),
        .wr_beat           (wr_beat),
        .gen_count         (gen_count),
        .copy_done         (copy_done),
        .time_cost         (time_cost)
    );

    initial begin
        afu_pcie_core_clk = 1'b0;
        forever #2 afu_pcie_core_clk = ~afu_pcie_core_clk;
    end

    // ==============================
    // checks and helpers
    // ==============================
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic check_cmd(input copy_desc_pkg::xfer_cmd_t got,
                             input copy_desc_pkg::xfer_cmd_t exp, input string what);
        string got_s;
        string exp_s;
        check_count++;
        if (got !== exp) begin
            got_s = $sformatf("addr %h len %0d beats %0d fn %h",
                got.addr, got.len, got.beats, got.function_num);
            exp_s = $sformatf("addr %h len %0d beats %0d fn %h",
                exp.addr, exp.len, exp.beats, exp.function_num);
            report_error($sformatf("%s: got %s, exp %s", what, got_s, exp_s));
        end
    endtask

    task automatic check_beat(input copy_desc_pkg::data_beat_t got,
                              input copy_desc_pkg::data_beat_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            report_error($sformatf("%s: got last %b data %h.., exp last %b data %h..",
                what, got.last, got.data[63:0], exp.last, exp.data[63:0]));
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    // ==============================
    // downstream model
    // ==============================
    task automatic monitor_cmds();
        copy_desc_pkg::xfer_cmd_t  exp_rd;
        copy_desc_pkg::xfer_cmd_t  exp_wr;
        copy_desc_pkg::data_beat_t beat;
        logic [63:0]               room;
        logic [15:0]               beats;
        check_word(32'(wr_cmd_valid), 32'(rd_cmd_valid), "write command valid");
        if (rd_cmd_valid !== 1'b1) begin
            return;
        end
        if (!row_active) begin
            report_error("command issued while no copy was running");
            return;
        end
        room = 64'(page_bytes) - (run_off % 64'(page_bytes));
        if (rd_cmd.len == 16'd0 || 64'(rd_cmd.len) > room ||
            64'(rd_cmd.len) > 64'(cur_cfg.size) - run_off) begin
            report_error($sformatf("bad chunk len %0d at offset %0d", rd_cmd.len, run_off));
            return;
        end
        beats = 16'(((run_off + 64'(rd_cmd.len) - 64'd1) / beat_size) - (run_off / beat_size) + 1);
        exp_rd.addr         = cur_cfg.rd_base + run_off;
        exp_rd.len          = rd_cmd.len;
        exp_rd.beats        = beats;
        exp_rd.function_num = fn_value;
        exp_wr              = exp_rd;
        exp_wr.addr         = cur_cfg.wr_base + run_off;
        check_cmd(rd_cmd, exp_rd, "read command");
        check_cmd(wr_cmd, exp_wr, "write command");
        for (int i = 0; i < int'(beats); i++) begin
            beat.last = (i == int'(beats) - 1);
            beat.data = {8{exp_rd.addr + 64'(i)}};
            beat_q.push_back(beat);
        end
        issued_beats += int'(beats);
        run_off      += 64'(rd_cmd.len);
        cmd_count++;
        if (issued_beats - consumed_beats > max_outstanding) begin
            report_error($sformatf("%0d beats outstanding", issued_beats - consumed_beats));
        end
    endtask

    task automatic monitor_data();
        logic exp_valid;
        exp_valid = rd_data_valid && (work_mode == copy_ctrl_pkg::copy_mode);
        check_word(32'(wr_data_valid), 32'(exp_valid), "wr_data_valid");
        if (wr_data_valid === 1'b1) begin
            fwd_count++;
        end
        if (exp_valid) begin
            check_beat(wr_beat, rd_beat, "forwarded beat");
            unconsumed++;
        end
    endtask

    always @(negedge afu_pcie_core_clk) begin
        if (!afu_pcie_core_rst) begin
            monitor_cmds();
            monitor_data();
        end
    end

    // one read beat per cycle, wr_data_ren at a random rate
    always @(posedge afu_pcie_core_clk) begin
        if (!afu_pcie_core_rst) begin
            if (beat_q.size() != 0) begin
                rd_data_valid <= 1'b1;
                rd_beat       <= beat_q.pop_front();
            end
            else begin
                rd_data_valid <= 1'b0;
            end
            if (!hold_ren && unconsumed != 0 && next_rand_bit()) begin
                wr_data_ren <= 1'b1;
                unconsumed--;
                consumed_beats++;
            end
            else begin
                wr_data_ren <= 1'b0;
            end
        end
    end

    // ==============================
    // sequences
    // ==============================
    task automatic wait_done(input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge afu_pcie_core_clk);
        while (copy_done !== level && n < limit) begin
            @(negedge afu_pcie_core_clk);
            n++;
        end
        if (copy_done !== level) begin
            timeout_count++;
            timed_out = 1'b1;
            $display("timeout: %s did not happen within %0d cycles", what, limit);
        end
    endtask

    task automatic wait_outstanding(input int level, input int limit);
        int n;
        n = 0;
        while (issued_beats - consumed_beats < level && n < limit) begin
            @(negedge afu_pcie_core_clk);
            n++;
        end
        if (issued_beats - consumed_beats < level) begin
            timeout_count++;
            timed_out = 1'b1;
            $display("timeout: outstanding beats never reached %0d", level);
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] cost;
        @(posedge afu_pcie_core_clk);
        copy_cfg       <= rows[r].cfg;
        copy_cmd_valid <= 1'b1;
        work_mode      <= copy_ctrl_pkg::copy_mode;
        cur_cfg    = rows[r].cfg;
        run_off    = 64'd0;
        cmd_count  = 0;
        hold_ren   = rows[r].hold;
        row_active = 1'b1;
        @(posedge afu_pcie_core_clk);
        copy_cmd_valid <= 1'b0;
        work_en        <= 1'b1;
        @(posedge afu_pcie_core_clk);
        work_en <= 1'b0;
        wait_done(1'b0, 16, "copy_done fall after start");
        if (timed_out) begin
            return;
        end
        if (rows[r].hold) begin
            wait_outstanding(32, 4000);
            if (timed_out) begin
                return;
            end
            repeat (64) @(negedge afu_pcie_core_clk);   // pops must stall on credit
            hold_ren = 1'b0;
        end
        wait_done(1'b1, 40000, "copy_done rise");
        if (timed_out) begin
            return;
        end
        row_active = 1'b0;
        check_word(run_off[31:0], rows[r].cfg.size, "bytes covered by commands");
        check_word(32'(consumed_beats), 32'(issued_beats), "beats consumed at copy_done");
        check_word(32'(beat_q.size()), 32'd0, "read beats still queued");
        check_word({16'd0, gen_count}, 32'(cmd_count), "gen_count");
        if (cmd_count < int'(rows[r].min_cmds)) begin
            report_error($sformatf("row %0d gave only %0d commands", r, cmd_count));
        end
        cost = time_cost;
        if (cost == 32'd0) begin
            report_error("time_cost is zero after the copy");
        end
        repeat (4) @(negedge afu_pcie_core_clk);
        check_word(time_cost, cost, "time_cost after done");
    endtask

    // fifo mode: no forwarding, enable starts nothing
    task automatic check_fifo_mode();
        copy_desc_pkg::data_beat_t beat;
        int                        fwd_before;
        @(posedge afu_pcie_core_clk);
        work_mode <= copy_ctrl_pkg::fifo_mode;
        work_en   <= 1'b1;
        @(posedge afu_pcie_core_clk);
        work_en <= 1'b0;
        @(negedge afu_pcie_core_clk);
        fwd_before = fwd_count;
        for (int i = 0; i < 4; i++) begin
            beat.last = (i == 3);
            beat.data = {8{64'hf1f0_0000 + 64'(i)}};
            beat_q.push_back(beat);
        end
        for (int i = 0; i < 40; i++) begin
            @(negedge afu_pcie_core_clk);
            check_word(32'(copy_done), 32'd1, "copy_done in fifo mode");
        end
        check_word(32'(fwd_count - fwd_before), 32'd0, "beats forwarded in fifo mode");
    endtask

    // ==============================
    // main
    // ==============================
    initial begin
        rows[0] = '{'{64'h0000_0001_0000_0000, 64'h0000_0002_0000_0000, 32'd8192, 12'h5a3},
                    1'b0, 16'd2};
        rows[1] = '{'{64'h0000_0000_0040_0100, 64'h0000_0000_0080_0000, 32'd5013, 12'h0c1},
                    1'b0, 16'd2};
        rows[2] = '{'{64'h0000_0003_0000_0040, 64'h0000_0004_0000_0000, 32'd12000, 12'h000},
                    1'b0, 16'd3};   // zero seed
        rows[3] = '{'{64'h0000_0005_0000_0000, 64'h0000_0006_0000_1000, 32'd65536, 12'hfff},
                    1'b1, 16'd16};
        afu_pcie_core_rst = 1'b1;
        copy_cmd_valid    = 1'b0;
        copy_cfg          = '0;
        work_mode         = copy_ctrl_pkg::fifo_mode;
        work_en           = 1'b0;
        function_num      = fn_value;
        rd_data_valid     = 1'b0;
        rd_beat           = '0;
        wr_data_ren       = 1'b0;
        repeat (8) @(posedge afu_pcie_core_clk);
        afu_pcie_core_rst <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            if (!timed_out) begin
                run_row(r);
            end
        end
        if (!timed_out) begin
            check_fifo_mode();
        end
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/onboard_copy_top.sv ====
// on-board copy engine top
// decode, chunk generation, chunk fifo and command issue
`default_nettype none

module onboard_copy_top #(
    parameter int fifo_aw      = 9,
    parameter int fifo_afull   = 448,
    parameter int credit_limit = 480
) (
    input  logic                      afu_pcie_core_clk,
    input  logic                      afu_pcie_core_rst,
    input  logic                      copy_cmd_valid,
    input  copy_desc_pkg::copy_cfg_t  copy_cfg,
    input  copy_ctrl_pkg::work_mode_e work_mode,
    input  logic                      work_en,
    input  logic [7:0]                function_num,
    output logic                      rd_cmd_valid,
    output copy_desc_pkg::xfer_cmd_t  rd_cmd,
    output logic                      wr_cmd_valid,
    output copy_desc_pkg::xfer_cmd_t  wr_cmd,
    input  logic                      rd_data_valid,
    input  copy_desc_pkg::data_beat_t rd_beat,
    input  logic                      wr_data_ren,
    output logic                      wr_data_valid,
    output copy_desc_pkg::data_beat_t wr_beat,
    output logic [15:0]               gen_count,
    output logic                      copy_done,
    output logic [31:0]               time_cost
);

    copy_desc_pkg::copy_cfg_t   cfg;
    copy_desc_pkg::chunk_desc_t gen_desc;
    copy_desc_pkg::chunk_desc_t head;
    logic copy_sel;
    logic start;
    logic gen_idle;
    logic push;
    logic afull;
    logic empty;
    logic pop;

    // ==============================
    // decode stage
    // ==============================
    copy_cmd_decode u_decode (
        .afu_pcie_core_clk (afu_pcie_core_clk),
        .afu_pcie_core_rst (afu_pcie_core_rst),
        .copy_cmd_valid    (copy_cmd_valid),
        .cfg_in            (copy_cfg),
        .work_mode         (work_mode),
        .work_en           (work_en),
        .gen_idle          (gen_idle),
        .cfg               (cfg),
        .copy_sel          (copy_sel),
        .start             (start)
    );

    // ==============================
    // execute stage
    // ==============================
    chunk_gen u_gen (
        .afu_pcie_core_clk (afu_pcie_core_clk),
        .afu_pcie_core_rst (afu_pcie_core_rst),
        .start             (start),
        .cfg               (cfg),
        .fifo_afull        (afull),
        .gen_idle          (gen_idle),
        .push              (push),
        .desc              (gen_desc),
        .gen_count         (gen_count)
    );

    chunk_fifo #(
        .fifo_aw    (fifo_aw),
        .fifo_afull (fifo_afull)
    ) u_fifo (
        .afu_pcie_core_clk (afu_pcie_core_clk),
        .afu_pcie_core_rst (afu_pcie_core_rst),
        .push              (push),
        .wdesc             (gen_desc),
        .pop               (pop),
        .rdesc             (head),
        .empty             (empty),
        .afull             (afull)
    );

    // ==============================
    // result stage
    // ==============================
    cmd_issue #(
        .credit_limit (credit_limit)
    ) u_issue (
        .afu_pcie_core_clk (afu_pcie_core_clk),
        .afu_pcie_core_rst (afu_pcie_core_rst),
        .start             (start),
        .copy_sel          (copy_sel),
        .gen_idle          (gen_idle),
        .cfg               (cfg),
        .function_num      (function_num),
        .head              (head),
        .empty             (empty),
        .pop               (pop),
        .rd_cmd_valid      (rd_cmd_valid),
        .rd_cmd            (rd_cmd),
        .wr_cmd_valid      (wr_cmd_valid),
        .wr_cmd            (wr_cmd),
        .rd_data_valid     (rd_data_valid),
        .rd_beat           (rd_beat),
        .wr_data_ren       (wr_data_ren),
        .wr_data_valid     (wr_data_valid),
        .wr_beat           (wr_beat),
        .copy_done         (copy_done),
        .time_cost         (time_cost)
    );

endmodule

`default_nettype wire

// ==== source/cmd_issue.sv ====
// command issue stage
// turns chunks into paired read and write commands and tracks copy completion
`default_nettype none

module cmd_issue #(
    parameter int credit_limit = 480
) (
    input  logic                       afu_pcie_core_clk,
    input  logic                       afu_pcie_core_rst,
    input  logic                       start,
    input  logic                       copy_sel,
    input  logic                       gen_idle,
    input  copy_desc_pkg::copy_cfg_t   cfg,
    input  logic [7:0]                 function_num,
    input  copy_desc_pkg::chunk_desc_t head,
    input  logic                       empty,
    output logic                       pop,
    output logic                       rd_cmd_valid,
    output copy_desc_pkg::xfer_cmd_t   rd_cmd,
    output logic                       wr_cmd_valid,
    output copy_desc_pkg::xfer_cmd_t   wr_cmd,
    input  logic                       rd_data_valid,
    input  copy_desc_pkg::data_beat_t  rd_beat,
    input  logic                       wr_data_ren,
    output logic                       wr_data_valid,
    output copy_desc_pkg::data_beat_t  wr_beat,
    output logic                       copy_done,
    output logic [31:0]                time_cost
);

    logic [15:0] credit;        // beats issued but not yet consumed
    logic        beat_taken;

    assign beat_taken = wr_data_ren && copy_sel;

    // ==============================
    // pop pacing and commands
    // ==============================
    always_ff @(posedge afu_pcie_core_clk or posedge afu_pcie_core_rst) begin
        if (afu_pcie_core_rst) begin
            pop <= 1'b0;
        end
        else begin
            pop <= !empty && !pop && (credit < credit_limit[15:0]);
        end
    end

    always_comb begin
        rd_cmd.addr         = cfg.rd_base + head.offset;
        rd_cmd.len          = head.len;
        rd_cmd.beats        = head.beats;
        rd_cmd.function_num = function_num;
        wr_cmd.addr         = cfg.wr_base + head.offset;
        wr_cmd.len          = head.len;
        wr_cmd.beats        = head.beats;
        wr_cmd.function_num = function_num;
    end

    assign rd_cmd_valid = pop;      // both sides issue together
    assign wr_cmd_valid = pop;

    // ==============================
    // beat credit and data path
    // ==============================
    always_ff @(posedge afu_pcie_core_clk or posedge afu_pcie_core_rst) begin
        if (afu_pcie_core_rst) begin
            credit <= 16'd0;
        end
        else begin
            case ({pop, beat_taken})
                2'b10:   credit <= credit + head.beats;
                2'b01:   credit <= credit - 16'd1;
                2'b11:   credit <= credit + head.beats - 16'd1;
                default: credit <= credit;
            endcase
        end
    end

    assign wr_data_valid = rd_data_valid && copy_sel;   // no forwarding in fifo mode
    assign wr_beat       = rd_beat;

    // done flag and cycle count
    always_ff @(posedge afu_pcie_core_clk or posedge afu_pcie_core_rst) begin
        if (afu_pcie_core_rst) begin
            copy_done <= 1'b1;
            time_cost <= 32'd0;
        end
        else if (start) begin
            copy_done <= 1'b0;
            time_cost <= 32'd0;
        end
        else begin
            if (gen_idle && empty && credit == 16'd0) begin
                copy_done <= 1'b1;
            end
            if (!copy_done) begin
                time_cost <= time_cost + 32'd1;
            end
        end
    end

    // downstream may only consume beats that were issued
    a_credit_floor: assert property (
        @(posedge afu_pcie_core_clk) disable iff (afu_pcie_core_rst)
        beat_taken |-> (credit != 16'd0) || pop
    ) else $error("beat credit underflow");

endmodule

`default_nettype wire

// ==== source/chunk_fifo.sv ====
// chunk descriptor fifo
// show-ahead register fifo between the generator and the issue stage
`default_nettype none

module chunk_fifo #(
    parameter int fifo_aw    = 9,
    parameter int fifo_afull = 448
) (
    input  logic                       afu_pcie_core_clk,
    input  logic                       afu_pcie_core_rst,
    input  logic                       push,
    input  copy_desc_pkg::chunk_desc_t wdesc,
    input  logic                       pop,
    output copy_desc_pkg::chunk_desc_t rdesc,
    output logic                       empty,
    output logic                       afull
);

    localparam int depth = 1 << fifo_aw;

    copy_desc_pkg::chunk_desc_t mem [depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   fill;       // words held
    logic               full;

    // ==============================
    // storage
    // ==============================
    always_ff @(posedge afu_pcie_core_clk) begin
        if (push) begin
            mem[wr_ptr] <= wdesc;
        end
    end

    assign rdesc = mem[rd_ptr];     // head always visible

    // ==============================
    // pointers and fill count
    // ==============================
    always_ff @(posedge afu_pcie_core_clk or posedge afu_pcie_core_rst) begin
        if (afu_pcie_core_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;      // idle or both
            endcase
        end
    end

    assign empty = (fill == '0);
    assign full  = (fill == depth[fifo_aw:0]);
    assign afull = (fill >= fifo_afull[fifo_aw:0]);

    a_no_xflow: assert property (
        @(posedge afu_pcie_core_clk) disable iff (afu_pcie_core_rst)
        !(push && full) && !(pop && empty)
    ) else $error("chunk fifo overflow or underflow");

endmodule

`default_nettype wire

// ==== source/chunk_gen.sv ====
// chunk generator
// splits one copy into random-length chunks that never cross a 4 KiB boundary
`default_nettype none

module chunk_gen (
    input  logic                       afu_pcie_core_clk,
    input  logic                       afu_pcie_core_rst,
    input  logic                       start,
    input  copy_desc_pkg::copy_cfg_t   cfg,
    input  logic                       fifo_afull,
    output logic                       gen_idle,
    output logic                       push,
    output copy_desc_pkg::chunk_desc_t desc,
    output logic [15:0]                gen_count
);

    localparam int bnd_w  = $clog2(copy_desc_pkg::boundary_bytes);
    localparam int beat_w = $clog2(copy_desc_pkg::beat_bytes);
    localparam logic [bnd_w:0] bnd_size = copy_desc_pkg::boundary_bytes[bnd_w:0];

    copy_ctrl_pkg::gen_state_e state;
    logic [11:0]    lfsr;
    logic           lfsr_fb;
    logic [63:0]    cur_off;        // offset of the next chunk
    logic [31:0]    left;           // bytes not yet split off
    logic           advance;
    logic [bnd_w:0] room;
    logic [bnd_w:0] rand_lim;
    logic [15:0]    chunk_len;
    logic           last_chunk;
    logic [63:0]    end_off;
    logic [15:0]    chunk_beats;

    // ==============================
    // chunk arithmetic
    // ==============================
    assign advance  = (state == copy_ctrl_pkg::st_copy) && !fifo_afull;
    assign room     = bnd_size - {1'b0, cur_off[bnd_w-1:0]};   // 1 up to 4096
    assign lfsr_fb  = lfsr[11] ^ lfsr[5] ^ lfsr[3] ^ lfsr[0];

    always_comb begin
        // zero lfsr value means no random limit
        if (lfsr == 12'h000 || {1'b0, lfsr} > room) begin
            rand_lim = room;
        end
        else begin
            rand_lim = {1'b0, lfsr};
        end
        if (left < 32'(rand_lim)) begin
            chunk_len = left[15:0];
        end
        else begin
            chunk_len = 16'(rand_lim);
        end
    end

    assign last_chunk  = (32'(chunk_len) == left);
    assign end_off     = cur_off + 64'(chunk_len) - 64'd1;     // last byte of the chunk
    assign chunk_beats = 16'(end_off[bnd_w-1:beat_w] - cur_off[bnd_w-1:beat_w]) + 16'd1;

    // ==============================
    // fsm, lfsr and counters
    // ==============================
    always_ff @(posedge afu_pcie_core_clk or posedge afu_pcie_core_rst) begin
        if (afu_pcie_core_rst) begin
            state     <= copy_ctrl_pkg::st_idle;
            lfsr      <= 12'h001;
            push      <= 1'b0;
            gen_count <= 16'd0;
        end
        else begin
            push <= advance && (left != 32'd0);
            if (start) begin
                state     <= copy_ctrl_pkg::st_copy;
                lfsr      <= cfg.seed;
                gen_count <= 16'd0;
            end
            else if (advance) begin
                if (last_chunk) begin
                    state <= copy_ctrl_pkg::st_idle;
                end
                lfsr <= {lfsr[10:0], lfsr_fb};
                if (left != 32'd0) begin
                    gen_count <= gen_count + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge afu_pcie_core_clk) begin
        if (start) begin
            cur_off <= 64'd0;
            left    <= cfg.size;
        end
        else if (advance) begin
            cur_off <= cur_off + 64'(chunk_len);
            left    <= left - 32'(chunk_len);
        end
    end

    // descriptor goes out one cycle after it is computed
    always_ff @(posedge afu_pcie_core_clk) begin
        if (advance) begin
            desc.offset <= cur_off;
            desc.len    <= chunk_len;
            desc.beats  <= chunk_beats;
        end
    end

    // a start or a push in flight keeps the generator busy
    assign gen_idle = (state == copy_ctrl_pkg::st_idle) && !push && !start;

    a_chunk_ok: assert property (
        @(posedge afu_pcie_core_clk) disable iff (afu_pcie_core_rst)
        push |-> (desc.len != 16'd0) &&
                 (32'(desc.offset[bnd_w-1:0]) + 32'(desc.len) <= 32'(bnd_size))
    ) else $error("chunk is empty or crosses the boundary");

endmodule

`default_nettype wire

// ==== source/copy_cmd_decode.sv ====
// copy command decode
// holds the loaded copy command and raises the start pulse for a new copy
`default_nettype none

module copy_cmd_decode (
    input  logic                      afu_pcie_core_clk,
    input  logic                      afu_pcie_core_rst,
    input  logic                      copy_cmd_valid,
    input  copy_desc_pkg::copy_cfg_t  cfg_in,
    input  copy_ctrl_pkg::work_mode_e work_mode,
    input  logic                      work_en,
    input  logic                      gen_idle,
    output copy_desc_pkg::copy_cfg_t  cfg,
    output logic                      copy_sel,
    output logic                      start
);

    logic start_cond;

    // ==============================
    // command capture
    // ==============================
    always_ff @(posedge afu_pcie_core_clk) begin
        if (copy_cmd_valid) begin
            cfg <= cfg_in;
            if (cfg_in.seed == 12'h000) begin
                cfg.seed <= 12'h001;        // lfsr locks up on zero
            end
        end
    end

    // ==============================
    // mode decode and start
    // ==============================
    assign copy_sel = (work_mode == copy_ctrl_pkg::copy_mode);

    // generator must be idle with nothing in flight
    assign start_cond = work_en && copy_sel && gen_idle;

    always_ff @(posedge afu_pcie_core_clk or posedge afu_pcie_core_rst) begin
        if (afu_pcie_core_rst) begin
            start <= 1'b0;
        end
        else begin
            start <= start_cond;            // one cycle after the condition
        end
    end

    // a held enable must not retrigger while the generator wakes up
    a_start_single: assert property (
        @(posedge afu_pcie_core_clk) disable iff (afu_pcie_core_rst)
        start |=> !start
    ) else $error("start pulse lasted more than one cycle");

endmodule

`default_nettype wire

// ==== source/copy_ctrl_pkg.sv ====
// copy control package
// work mode and chunk generator state encodings
`default_nettype none

package copy_ctrl_pkg;

    // ==============================
    // work mode register field
    // ==============================
    typedef enum logic [3:0] {
        fifo_mode = 4'd0,   // commands come from the host fifo path
        copy_mode = 4'd1    // on-board copy engine drives the commands
    } work_mode_e;

    // ==============================
    // chunk generator fsm
    // ==============================
    typedef enum logic {
        st_idle,            // waiting for start
        st_copy             // splitting the copy into chunks
    } gen_state_e;

endpackage

`default_nettype wire

// ==== source/copy_desc_pkg.sv ====
// copy descriptor package
// command, chunk, transfer command and data beat layouts for the copy engine
`default_nettype none

package copy_desc_pkg;

    // ==============================
    // constants
    // ==============================
    localparam int boundary_bytes = 4096;   // chunks never cross this
    localparam int beat_bytes     = 64;     // one data beat

    // ==============================
    // structs
    // ==============================

    // copy command as loaded by software, 172 bits
    typedef struct packed {
        logic [63:0] rd_base;
        logic [63:0] wr_base;
        logic [31:0] size;      // bytes
        logic [11:0] seed;      // lfsr seed
    } copy_cfg_t;

    // one chunk of the copy, 96 bits
    typedef struct packed {
        logic [63:0] offset;    // from the start of the copy
        logic [15:0] len;       // bytes
        logic [15:0] beats;     // 64-byte beats touched
    } chunk_desc_t;

    // read or write command, 104 bits
    typedef struct packed {
        logic [63:0] addr;
        logic [15:0] len;
        logic [15:0] beats;
        logic [7:0]  function_num;
    } xfer_cmd_t;

    // data beat, 513 bits
    typedef struct packed {
        logic         last;     // final beat of a command
        logic [511:0] data;
    } data_beat_t;

endpackage

`default_nettype wire
